//--- fabric_defines.svh
`ifndef FABRIC_DEFINES_SVH
`define FABRIC_DEFINES_SVH

// ---------------------------------------------------------------------
// Tile sizing
// ---------------------------------------------------------------------

// Operand and result width
`define FABRIC_DATA_W 32

// Token tag carried end to end
`define FABRIC_TAG_W 4

// Opcode field, codes above 7 are illegal
`define FABRIC_OP_W 4

// Entries in each elastic buffer
`define FABRIC_FIFO_DEPTH 2

`endif

//--- fabric_pkg.sv
`default_nettype none

`include "fabric_defines.svh"

package fabric_pkg;

  // Shift amount comes from the low bits of operand b
  localparam int FABRIC_SHAMT_W = $clog2(`FABRIC_DATA_W);

  // ---------------------------------------------------------------------
  // Opcodes
  // ---------------------------------------------------------------------
  typedef enum logic [`FABRIC_OP_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    // Reserved code, passes operand a
    OP_PASS = 4'd7
  } fabric_op_e;

  // ---------------------------------------------------------------------
  // Tokens
  // ---------------------------------------------------------------------

  // Input token, raw opcode so illegal codes survive to decode
  typedef struct packed {
    logic [`FABRIC_TAG_W-1:0]  tag;
    logic [`FABRIC_OP_W-1:0]   opcode;
    logic [`FABRIC_DATA_W-1:0] a;
    logic [`FABRIC_DATA_W-1:0] b;
  } fabric_token_t;

  typedef struct packed {
    logic [`FABRIC_TAG_W-1:0]  tag;
    fabric_op_e                op;
    logic [`FABRIC_DATA_W-1:0] a;
    logic [`FABRIC_DATA_W-1:0] b;
    logic [FABRIC_SHAMT_W-1:0] shamt;
    logic                      illegal;
  } fabric_decoded_t;

  // Output token with flags
  typedef struct packed {
    logic [`FABRIC_TAG_W-1:0]  tag;
    logic [`FABRIC_DATA_W-1:0] data;
    logic                      err;
    logic                      zero;
    logic                      neg;
  } fabric_result_t;

endpackage

`default_nettype wire

//--- fabric_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// Elastic buffer with optional combinational bypass
// ---------------------------------------------------------------------
module fabric_fifo import fabric_pkg::*; #(
  parameter type payload_t  = fabric_token_t,
  parameter int  DEPTH      = `FABRIC_FIFO_DEPTH,
  parameter bit  BYPASSABLE = 1'b0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data,
  input  logic     bypass
);

  // Zero entries cannot hold a token
  if (DEPTH == 0) begin : g_depth_check
    $fatal(1, "fabric_fifo: DEPTH must be at least 1");
  end

  logic     bypass_en;
  logic     core_in_valid;
  logic     core_in_ready;
  payload_t core_in_data;
  logic     core_out_valid;
  logic     core_out_ready;
  payload_t core_out_data;

  // Bypass folds away on instances built without it
  assign bypass_en = BYPASSABLE ? bypass : 1'b0;

  always_comb begin
    if (bypass_en) begin
      // Straight wire, core sees no traffic
      out_valid      = in_valid;
      out_data       = in_data;
      in_ready       = out_ready;
      core_in_valid  = 1'b0;
      core_in_data   = '0;
      core_out_ready = 1'b0;
    end else begin
      core_in_valid  = in_valid;
      core_in_data   = in_data;
      in_ready       = core_in_ready;
      out_valid      = core_out_valid;
      out_data       = core_out_data;
      core_out_ready = out_ready;
    end
  end

  fabric_fifo_core #(
    .payload_t (payload_t),
    .DEPTH     (DEPTH)
  ) core_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (core_in_valid),
    .in_ready  (core_in_ready),
    .in_data   (core_in_data),
    .out_valid (core_out_valid),
    .out_ready (core_out_ready),
    .out_data  (core_out_data)
  );

endmodule

// ---------------------------------------------------------------------
// Circular buffer core
// ---------------------------------------------------------------------
module fabric_fifo_core import fabric_pkg::*; #(
  parameter type payload_t = fabric_token_t,
  parameter int  DEPTH     = `FABRIC_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Keep widths legal even when the wrapper rejects DEPTH
  localparam int SAFE_DEPTH = (DEPTH > 0) ? DEPTH : 1;
  localparam int PTR_W      = (SAFE_DEPTH > 1) ? $clog2(SAFE_DEPTH) : 1;
  localparam int CNT_W      = $clog2(SAFE_DEPTH + 1);

  payload_t   mem [SAFE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic       push;
  logic       pop;

  // Wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(SAFE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign pop       = out_valid && out_ready;
  // Full buffer still takes a write while the head leaves
  assign in_ready  = (count != CNT_W'(SAFE_DEPTH)) || pop;
  assign push      = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- fabric_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// Opcode decode between input buffer and ALU
// ---------------------------------------------------------------------
module fabric_decode import fabric_pkg::*; (
  input  logic            tok_valid,
  output logic            tok_ready,
  input  fabric_token_t   token,
  output logic            dec_valid,
  input  logic            dec_ready,
  output fabric_decoded_t dec
);

  logic legal;

  // Codes 0 to 7 are legal, 7 being the reserved pass
  assign legal = (token.opcode <= `FABRIC_OP_W'(OP_PASS));

  // No storage here, handshake goes straight through
  assign dec_valid = tok_valid;
  assign tok_ready = dec_ready;

  always_comb begin
    dec.tag     = token.tag;
    // Illegal codes still map, execute ignores them
    dec.op      = fabric_op_e'(token.opcode);
    dec.a       = token.a;
    dec.b       = token.b;
    // Only low bits of b shift
    dec.shamt   = token.b[FABRIC_SHAMT_W-1:0];
    dec.illegal = !legal;
  end

endmodule

`default_nettype wire

//--- fabric_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// One-stage ALU with output register
// ---------------------------------------------------------------------
module fabric_execute import fabric_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dec_valid,
  output logic            dec_ready,
  input  fabric_decoded_t dec,
  output logic            exe_valid,
  input  logic            exe_ready,
  output fabric_result_t  exe
);

  logic [`FABRIC_DATA_W-1:0] alu_data;
  fabric_result_t            exe_nxt;
  logic                      load;

  // ALU
  always_comb begin
    case (dec.op)
      OP_ADD:  alu_data = dec.a + dec.b;
      OP_SUB:  alu_data = dec.a - dec.b;
      OP_AND:  alu_data = dec.a & dec.b;
      OP_OR:   alu_data = dec.a | dec.b;
      OP_XOR:  alu_data = dec.a ^ dec.b;
      OP_SLL:  alu_data = dec.a << dec.shamt;
      OP_SRL:  alu_data = dec.a >> dec.shamt;
      // Reserved code 7
      default: alu_data = dec.a;
    endcase
  end

  always_comb begin
    exe_nxt.tag  = dec.tag;
    // Illegal tokens carry zero data and the error bit
    exe_nxt.data = dec.illegal ? '0 : alu_data;
    exe_nxt.err  = dec.illegal;
    // Flags are filled in by the result stage
    exe_nxt.zero = 1'b0;
    exe_nxt.neg  = 1'b0;
  end

  // Register free when empty or draining this cycle
  assign dec_ready = !exe_valid || exe_ready;
  assign load      = dec_valid && dec_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid <= 1'b0;
    end else if (dec_ready) begin
      exe_valid <= dec_valid;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (load) begin
      exe <= exe_nxt;
    end
  end

endmodule

`default_nettype wire

//--- fabric_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// Result flags and error counter
// ---------------------------------------------------------------------
module fabric_result import fabric_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           exe_valid,
  output logic           exe_ready,
  input  fabric_result_t exe,
  output logic           res_valid,
  input  logic           res_ready,
  output fabric_result_t res,
  output logic [15:0]    err_count
);

  logic xfer;

  // Data path is combinational
  assign res_valid = exe_valid;
  assign exe_ready = res_ready;
  assign xfer      = exe_valid && res_ready;

  always_comb begin
    res      = exe;
    res.zero = (exe.data == '0);
    // Sign bit of the result
    res.neg  = exe.data[`FABRIC_DATA_W-1];
  end

  // Sticky count of illegal tokens, holds at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (xfer && exe.err && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- fabric_tile.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// Arithmetic tile top level
// ---------------------------------------------------------------------
module fabric_tile import fabric_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  output logic           in_ready,
  input  fabric_token_t  in_token,
  output logic           out_valid,
  input  logic           out_ready,
  output fabric_result_t out_result,
  input  logic           bypass,
  output logic [15:0]    err_count
);

  // Input buffer to decode
  logic            tok_valid;
  logic            tok_ready;
  fabric_token_t   tok;
  // Decode to execute
  logic            dec_valid;
  logic            dec_ready;
  fabric_decoded_t dec;
  // Execute to result
  logic            exe_valid;
  logic            exe_ready;
  fabric_result_t  exe;
  // Result to output buffer
  logic            res_valid;
  logic            res_ready;
  fabric_result_t  res;

  fabric_fifo #(
    .payload_t  (fabric_token_t),
    .DEPTH      (`FABRIC_FIFO_DEPTH),
    .BYPASSABLE (1'b0)
  ) in_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_token),
    .out_valid (tok_valid),
    .out_ready (tok_ready),
    .out_data  (tok),
    .bypass    (1'b0)
  );

  fabric_decode decode_i (
    .tok_valid (tok_valid),
    .tok_ready (tok_ready),
    .token     (tok),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec)
  );

  fabric_execute execute_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe       (exe)
  );

  fabric_result result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe       (exe),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .err_count (err_count)
  );

  // Output buffer, bypass set from outside only while empty
  fabric_fifo #(
    .payload_t  (fabric_result_t),
    .DEPTH      (`FABRIC_FIFO_DEPTH),
    .BYPASSABLE (1'b1)
  ) out_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .in_data   (res),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_result),
    .bypass    (bypass)
  );

endmodule

`default_nettype wire

//--- fabric_tile_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

// ---------------------------------------------------------------------
// Handshake properties of the tile ports
// ---------------------------------------------------------------------
module fabric_tile_assertions import fabric_pkg::*; (
  input logic           clk,
  input logic           rst_n,
  input logic           in_valid,
  input logic           in_ready,
  input fabric_token_t  in_token,
  input logic           out_valid,
  input logic           out_ready,
  input fabric_result_t out_result,
  input logic           bypass,
  input logic           out_buf_valid
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Stalled input token stays put
  in_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_token))
  else begin
    $error("in_valid or in_token changed under stall");
    fail_count++;
  end

  out_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
  else begin
    $error("out_valid or out_result changed under stall");
    fail_count++;
  end

  reset_out_a : assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
  else begin
    $error("out_valid high right after reset");
    fail_count++;
  end

  // Bypass switches only over an empty output buffer
  bypass_empty_a : assert property (@(posedge clk) disable iff (!rst_n)
    $changed(bypass) |-> !out_buf_valid)
  else begin
    $error("bypass changed while the output buffer held data");
    fail_count++;
  end

endmodule

bind fabric_tile fabric_tile_assertions assertions_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .in_valid      (in_valid),
  .in_ready      (in_ready),
  .in_token      (in_token),
  .out_valid     (out_valid),
  .out_ready     (out_ready),
  .out_result    (out_result),
  .bypass        (bypass),
  .out_buf_valid (out_fifo_i.core_out_valid)
);

`default_nettype wire

//--- fabric_tile_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fabric_defines.svh"

module fabric_tile_tb import fabric_pkg::*; ();

  // ---------------------------------------------------------------------
  // Run length
  // ---------------------------------------------------------------------
  localparam int N_RANDOM   = 300;
  localparam int N_DIRECTED = 10;
  localparam int N_TOKENS   = 3 * N_RANDOM + N_DIRECTED;
  // Generous per token budget, stalls included
  localparam int MAX_CYCLES = 20 * N_TOKENS + 200;

  logic           clk;
  logic           rst_n;
  logic           in_valid;
  logic           in_ready;
  fabric_token_t  in_token;
  logic           out_valid;
  logic           out_ready;
  fabric_result_t out_result;
  logic           bypass;
  logic [15:0]    err_count;

  // Expected results in issue order
  fabric_result_t expected_q [$];
  int unsigned    illegal_issued;
  int unsigned    cycles;
  bit             stall_mode;
  int             stall_left;
  bit             saw_in_stall;

  fabric_tile dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_token   (in_token),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .bypass     (bypass),
    .err_count  (err_count)
  );

  always #5 clk = ~clk;

  // ---------------------------------------------------------------------
  // Reference model and helpers
  // ---------------------------------------------------------------------

  // Expected output token from the opcode rules
  function automatic fabric_result_t fabric_ref(input fabric_token_t t);
    fabric_result_t            r;
    logic [`FABRIC_DATA_W-1:0] d;
    logic [4:0]                sh;
    // Only the low five bits of b shift
    sh = t.b[4:0];
    case (t.opcode)
      4'd0: d = t.a + t.b;
      4'd1: d = t.a - t.b;
      4'd2: d = t.a & t.b;
      4'd3: d = t.a | t.b;
      4'd4: d = t.a ^ t.b;
      4'd5: d = t.a << sh;
      4'd6: d = t.a >> sh;
      // Reserved, passes a
      4'd7: d = t.a;
      default: d = '0;
    endcase
    r.tag  = t.tag;
    r.data = d;
    r.err  = (t.opcode > 4'd7);
    r.zero = (d == '0);
    r.neg  = d[`FABRIC_DATA_W-1];
    return r;
  endfunction

  function automatic fabric_token_t make_token(input logic [3:0] tag, input logic [3:0] op,
                                               input logic [31:0] a, input logic [31:0] b);
    fabric_token_t t;
    t.tag    = tag;
    t.opcode = op;
    t.a      = a;
    t.b      = b;
    return t;
  endfunction

  // Full opcode range, legal and illegal
  function automatic fabric_token_t random_token();
    fabric_token_t t;
    t.tag    = `FABRIC_TAG_W'($urandom);
    t.opcode = `FABRIC_OP_W'($urandom_range(0, 15));
    t.a      = $urandom;
    t.b      = $urandom;
    // Equal operands give zero for sub and xor
    if ($urandom_range(0, 7) == 0) begin
      t.b = t.a;
    end
    return t;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_result(input fabric_result_t got, input fabric_result_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED out_result: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED err_count: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  // Holds the token until the input buffer takes it
  task automatic send_token(input fabric_token_t tok);
    fabric_result_t exp;
    if ($urandom_range(0, 3) == 0) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    exp = fabric_ref(tok);
    in_valid <= 1'b1;
    in_token <= tok;
    expected_q.push_back(exp);
    if (exp.err) begin
      illegal_issued++;
    end
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_drained();
    while (expected_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  // ---------------------------------------------------------------------
  // Output side: ready pattern, compare and timeout
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    if (!stall_mode) begin
      out_ready <= 1'b1;
    end else if (stall_left > 0) begin
      out_ready <= 1'b0;
      stall_left = stall_left - 1;
    end else if ($urandom_range(0, 24) == 0) begin
      // Long stall backs up into the input buffer
      stall_left = $urandom_range(8, 16);
      out_ready <= 1'b0;
    end else begin
      out_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk) begin
    if (rst_n && in_valid && !in_ready) begin
      saw_in_stall = 1'b1;
    end
    if (rst_n && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        report_failure("An output token arrived when none was expected");
      end else begin
        check_result(out_result, expected_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      report_failure($sformatf("Timeout after %0d cycles, %0d results still missing",
                               cycles, expected_q.size()));
    end else if (dut_i.assertions_i.fail_count != 0) begin
      // Bound handshake properties
      report_failure("A handshake assertion on the tile ports failed");
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(32'h0b48e240));
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_token       = '0;
    out_ready      = 1'b0;
    bypass         = 1'b0;
    stall_mode     = 1'b0;
    stall_left     = 0;
    illegal_issued = 0;
    cycles         = 0;
    saw_in_stall   = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // State right after reset
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
    check_count(err_count, 16'h0000);

    // Free flowing output
    repeat (N_RANDOM) send_token(random_token());
    in_valid <= 1'b0;
    wait_drained();

    // Random stalls and long bursts
    stall_mode <= 1'b1;
    repeat (N_RANDOM) send_token(random_token());
    in_valid <= 1'b0;
    stall_mode <= 1'b0;
    wait_drained();
    if (!saw_in_stall) begin
      report_failure("in_ready never fell while the output was stalled");
    end

    // Output buffer empty, bypass may switch
    bypass <= 1'b1;
    @(posedge clk);
    repeat (N_RANDOM) send_token(random_token());
    in_valid <= 1'b0;
    wait_drained();
    bypass <= 1'b0;
    @(posedge clk);

    // Directed edge cases
    send_token(make_token(4'h1, 4'd1, 32'h0000_0005, 32'h0000_0007));
    send_token(make_token(4'h2, 4'd5, 32'h0000_0001, 32'h0000_001f));
    send_token(make_token(4'h3, 4'd6, 32'h8000_0000, 32'h0000_001f));
    // High bits of b ignored by shifts
    send_token(make_token(4'h4, 4'd5, 32'h0000_00ff, 32'hffff_ffe3));
    send_token(make_token(4'h5, 4'd6, 32'hf000_0000, 32'h1234_5664));
    send_token(make_token(4'h6, 4'd4, 32'h5a5a_a5a5, 32'h5a5a_a5a5));
    send_token(make_token(4'h7, 4'd0, 32'hffff_ffff, 32'h0000_0001));
    send_token(make_token(4'h8, 4'd2, 32'h1234_5678, 32'h0000_0000));
    send_token(make_token(4'h9, 4'd7, 32'hdead_beef, 32'h0000_0000));
    send_token(make_token(4'ha, 4'd15, 32'h0000_0001, 32'h0000_0001));
    in_valid <= 1'b0;
    wait_drained();

    check_count(err_count, 16'(illegal_issued));
    if (dut_i.assertions_i.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_failure($sformatf("%0d handshake assertion failures",
                               dut_i.assertions_i.fail_count));
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
fabric_pkg.sv
fabric_fifo.sv
fabric_decode.sv
fabric_execute.sv
fabric_result.sv
fabric_tile.sv
fabric_tile_assertions.sv
fabric_tile_tb.sv

//--- Bender.yml
package:
  name: fabric_tile

export_include_dirs:
  - .

sources:
  - fabric_pkg.sv
  - fabric_fifo.sv
  - fabric_decode.sv
  - fabric_execute.sv
  - fabric_result.sv
  - fabric_tile.sv
  - target: test
    files:
      - fabric_tile_assertions.sv
      - fabric_tile_tb.sv
